//--- rtl/memSys_consts.svh
`ifndef MEMSYS_CONSTS_SVH
`define MEMSYS_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data word and external bus
`define MEM_DATA_W    32
`define EXT_ADDR_W    30
`define EXT_RD_LAT    2        // Cycles from read command word to first word

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// On-chip SRAMs
`define DRAM_DEPTH    1024
`define DRAM_ADDR_W   10
`define IRAM_DEPTH    512
`define IRAM_ADDR_W   9
`define IRAM_W        64
`define FETCH_ADDR_W  8        // One fetch line is 128 bits

`endif

//--- rtl/memSysPkg.sv
`include "memSys_consts.svh"

package memSysPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transfer commands
    typedef enum logic {
        MOP_LOAD,               // External memory to SRAM
        MOP_STORE               // SRAM to external memory
    } MemOp;

    typedef enum logic {
        TGT_DATA,
        TGT_INSTR
    } MemTarget;

    typedef enum logic [2:0] {
        IDLE,
        CMD,
        WAIT,
        XFER,
        DONE
    } CtrlState;

    typedef struct packed {
        MemOp                     op;
        MemTarget                 target;
        logic [`DRAM_ADDR_W-1:0]  sramAddr;   // Word index in the target RAM
        logic [`EXT_ADDR_W-1:0]   extAddr;
        logic [7:0]               len;        // Word count
    } MemCmd;

    typedef struct packed {
        logic busy;
        logic done;
    } MemStat;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SRAM access request, active high
    typedef struct packed {
        logic                     ce;
        logic                     we;
        logic [3:0]               wm;
        logic [`DRAM_ADDR_W-1:0]  addr;
        logic [`MEM_DATA_W-1:0]   data;
    } RamReq;

endpackage

//--- rtl/dualPortRam.sv
`timescale 1ns/10ps

module dualPortRam #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 1024
) (
    input  logic                     SPI_clk,

    input  logic                     nce,
    input  logic                     nwe,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         data,
    input  logic [WIDTH/8-1:0]       wm,
    output logic [WIDTH-1:0]         rdata,

    input  logic                     nce1,
    input  logic [$clog2(DEPTH)-1:0] addr1,
    output logic [WIDTH-1:0]         rdata1
);

    logic [WIDTH-1:0] mem [DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Port 0, read/write with byte mask
    always_ff @(posedge SPI_clk) begin
        if (!nce) begin
            if (!nwe) begin
                for (int i = 0; i < WIDTH/8; i++) begin
                    if (wm[i]) begin
                        mem[addr][i*8 +: 8] <= data[i*8 +: 8];
                    end
                end
            end
            rdata <= mem[addr];                // Old contents on a write
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Port 1, read only
    always_ff @(posedge SPI_clk) begin
        if (!nce1) begin
            rdata1 <= mem[addr1];
        end
    end

    aAddrKnown: assert property (@(posedge SPI_clk) !nce |-> !$isunknown(addr))
        else $error("dualPortRam: unknown addr with nce low");

endmodule

//--- rtl/extBusMaster.sv
`timescale 1ns/10ps
`include "memSys_consts.svh"

module extBusMaster (
    input  logic                    SPI_clk,
    input  logic                    arstN,

    input  logic                    start,
    input  logic                    write,
    input  logic [`EXT_ADDR_W-1:0]  extAddr,
    input  logic [7:0]              len,

    input  logic [`MEM_DATA_W-1:0]  wrData,
    output logic                    wrNext,
    output logic [`MEM_DATA_W-1:0]  rdData,
    output logic                    rdValid,
    output logic                    finish,

    output logic                    extEn,
    output logic                    extOen,
    output logic [`MEM_DATA_W-1:0]  extBusOut,
    input  logic [`MEM_DATA_W-1:0]  extBusIn
);

    logic                   wrMode;
    logic [8:0]             cnt;       // Cycles since the command word
    logic [8:0]             lastCnt;
    logic [7:0]             lenReg;
    logic [`MEM_DATA_W-1:0] cmdWord;

    // Writes end with word len, reads wait out the latency first
    assign lastCnt = wrMode ? {1'b0, lenReg}
                            : {1'b0, lenReg} + 9'(`EXT_RD_LAT - 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Burst control
    always_ff @(posedge SPI_clk or negedge arstN) begin
        if (!arstN) begin
            extEn  <= 1'b0;
            extOen <= 1'b0;
            wrMode <= 1'b0;
            cnt    <= '0;
        end else if (!extEn) begin
            if (start) begin
                extEn  <= 1'b1;
                extOen <= 1'b1;            // Command word is always driven
                wrMode <= write;
                cnt    <= '0;
            end
        end else if (cnt == lastCnt) begin
            extEn  <= 1'b0;
            extOen <= 1'b0;
        end else begin
            extOen <= wrMode;              // Slave owns the bus on reads
            cnt    <= cnt + 9'd1;
        end
    end

    always_ff @(posedge SPI_clk) begin
        if (!extEn && start) begin
            lenReg  <= len;
            cmdWord <= {write, 1'b0, extAddr};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data path
    assign wrNext  = extEn && wrMode && (cnt < {1'b0, lenReg});    // SRAM read one cycle ahead
    assign rdValid = extEn && !wrMode && (cnt >= 9'(`EXT_RD_LAT));
    assign rdData  = extBusIn;
    assign finish  = extEn && (cnt == lastCnt);

    always_comb begin
        if (!extOen) begin
            extBusOut = '0;
        end else if (cnt == 9'd0) begin
            extBusOut = cmdWord;
        end else begin
            extBusOut = wrData;
        end
    end

    aOenInBurst: assert property (@(posedge SPI_clk) disable iff (!arstN) !extEn |-> !extOen)
        else $error("extBusMaster: extOen high outside a burst");

endmodule

//--- rtl/memController.sv
`timescale 1ns/10ps
`include "memSys_consts.svh"

module memController
    import memSysPkg::*;
(
    input  logic                    SPI_clk,
    input  logic                    arstN,

    input  MemCmd                   cmd,
    input  logic                    cmdValid,
    output logic                    cmdReady,
    output MemStat                  stat,

    output RamReq                   mcReq,
    output MemTarget                mcTarget,
    input  logic [`MEM_DATA_W-1:0]  mcRdata,

    output logic                    extEn,
    output logic                    extOen,
    output logic [`MEM_DATA_W-1:0]  extBusOut,
    input  logic [`MEM_DATA_W-1:0]  extBusIn
);

    CtrlState                 state;
    CtrlState                 stateNext;
    MemCmd                    cmdReg;
    logic [`DRAM_ADDR_W-1:0]  sramAddr;

    logic                     start;
    logic                     wrNext;
    logic [`MEM_DATA_W-1:0]   rdData;
    logic                     rdValid;
    logic                     finish;
    logic                     wordCycle;

    assign cmdReady  = (state == IDLE);
    assign start     = (state == CMD);
    assign wordCycle = (cmdReg.op == MOP_STORE) ? wrNext : rdValid;

    assign stat.busy = (state != IDLE);
    assign stat.done = (state == DONE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer
    always_comb begin
        stateNext = state;
        case (state)
            IDLE: if (cmdValid) stateNext = CMD;
            CMD:  stateNext = WAIT;
            WAIT: begin
                if (finish) begin
                    stateNext = DONE;          // Single-word load
                end else if (wordCycle) begin
                    stateNext = XFER;
                end
            end
            XFER: if (finish) stateNext = DONE;
            DONE: stateNext = IDLE;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge SPI_clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge SPI_clk) begin
        if (cmdValid && cmdReady) begin
            cmdReg   <= cmd;
            sramAddr <= cmd.sramAddr;
        end else if (wordCycle) begin
            sramAddr <= sramAddr + 1'b1;       // Next word of the burst
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SRAM request, held for the whole bus burst
    assign mcReq.ce   = extEn;
    assign mcReq.we   = (cmdReg.op == MOP_LOAD) && rdValid;
    assign mcReq.wm   = 4'hf;
    assign mcReq.addr = sramAddr;
    assign mcReq.data = rdData;
    assign mcTarget   = cmdReg.target;

    extBusMaster i_extBusMaster (
        .SPI_clk   (SPI_clk),
        .arstN     (arstN),
        .start     (start),
        .write     (cmdReg.op == MOP_STORE),
        .extAddr   (cmdReg.extAddr),
        .len       (cmdReg.len),
        .wrData    (mcRdata),
        .wrNext    (wrNext),
        .rdData    (rdData),
        .rdValid   (rdValid),
        .finish    (finish),
        .extEn     (extEn),
        .extOen    (extOen),
        .extBusOut (extBusOut),
        .extBusIn  (extBusIn)
    );

    aLenNonZero: assert property (@(posedge SPI_clk) disable iff (!arstN)
        (cmdValid && cmdReady) |-> (cmd.len != 8'd0))
        else $error("memController: command accepted with len 0");

    aIdleNoAccess: assert property (@(posedge SPI_clk) disable iff (!arstN)
        (state == IDLE) |-> !mcReq.ce)
        else $error("memController: SRAM access while idle");

endmodule

//--- rtl/ramArbiter.sv
`timescale 1ns/10ps
`include "memSys_consts.svh"

module ramArbiter
    import memSysPkg::*;
(
    input  logic                      SPI_clk,

    input  RamReq                     mcReq,
    input  MemTarget                  mcTarget,
    output logic [`MEM_DATA_W-1:0]    mcRdata,

    input  RamReq                     dataWr,
    input  logic                      dataRe,
    input  logic [`DRAM_ADDR_W-1:0]   dataRaddr,
    output logic [`MEM_DATA_W-1:0]    dataRdata,
    output logic                      dataWbusy,

    input  logic                      fetchEn,
    input  logic [`FETCH_ADDR_W-1:0]  fetchAddr,
    output logic [2*`IRAM_W-1:0]      fetchData,
    output logic                      fetchBusy,

    output logic                      dramNce,
    output logic                      dramNwe,
    output logic [`DRAM_ADDR_W-1:0]   dramAddr,
    output logic [`MEM_DATA_W-1:0]    dramData,
    output logic [3:0]                dramWm,
    input  logic [`MEM_DATA_W-1:0]    dramRdata,
    output logic                      dramNce1,
    output logic [`DRAM_ADDR_W-1:0]   dramAddr1,
    input  logic [`MEM_DATA_W-1:0]    dramRdata1,

    output logic                      iramNce,
    output logic                      iramNwe,
    output logic [`IRAM_ADDR_W-1:0]   iramAddr,
    output logic [`IRAM_W-1:0]        iramData,
    output logic [`IRAM_W/8-1:0]      iramWm,
    input  logic [`IRAM_W-1:0]        iramRdata,
    output logic                      iramNce1,
    output logic [`IRAM_ADDR_W-1:0]   iramAddr1,
    input  logic [`IRAM_W-1:0]        iramRdata1
);

    logic mcData;
    logic mcInstr;

    assign mcData    = mcReq.ce && (mcTarget == TGT_DATA);
    assign mcInstr   = mcReq.ce && (mcTarget == TGT_INSTR);
    assign dataWbusy = mcData;
    assign fetchBusy = mcInstr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data RAM, controller has priority on port 0
    always_comb begin
        if (mcData) begin
            dramNce  = 1'b0;
            dramNwe  = !mcReq.we;
            dramAddr = mcReq.addr;
            dramData = mcReq.data;
            dramWm   = mcReq.wm;
        end else begin
            dramNce  = !dataWr.ce;
            dramNwe  = !dataWr.we;
            dramAddr = dataWr.addr;
            dramData = dataWr.data;
            dramWm   = dataWr.wm;
        end
    end

    assign dramNce1  = !dataRe;
    assign dramAddr1 = dataRaddr;
    assign dataRdata = dramRdata1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction RAM, two words per row
    assign iramNce  = mcInstr ? 1'b0 : !fetchEn;
    assign iramNwe  = mcInstr ? !mcReq.we : 1'b1;
    assign iramAddr = mcInstr ? mcReq.addr[`DRAM_ADDR_W-1:1] : {fetchAddr, 1'b1};
    assign iramData = {2{mcReq.data}};
    assign iramWm   = {mcReq.wm & {4{mcReq.addr[0]}}, mcReq.wm & {4{!mcReq.addr[0]}}};

    assign iramNce1  = !(fetchEn && !mcInstr);
    assign iramAddr1 = {fetchAddr, 1'b0};
    assign fetchData = {iramRdata, iramRdata1};    // Odd row on top

    // Address has stepped since the read, so the read half is the opposite parity
    assign mcRdata = (mcTarget == TGT_DATA) ? dramRdata
                   : (mcReq.addr[0] ? iramRdata[31:0] : iramRdata[63:32]);

    aSingleWriter: assert property (@(posedge SPI_clk)
        !(mcReq.we && (mcTarget == TGT_DATA) && dataWr.ce && dataWr.we && !dataWbusy))
        else $error("ramArbiter: two writers on the data RAM");

endmodule

//--- rtl/memSys.sv
`timescale 1ns/10ps
`include "memSys_consts.svh"

module memSys
    import memSysPkg::*;
(
    input  logic                      SPI_clk,
    input  logic                      arstN,

    input  MemCmd                     cmd,
    input  logic                      cmdValid,
    output logic                      cmdReady,
    output MemStat                    stat,

    input  RamReq                     dataWr,
    output logic                      dataWbusy,
    input  logic                      dataRe,
    input  logic [`DRAM_ADDR_W-1:0]   dataRaddr,
    output logic [`MEM_DATA_W-1:0]    dataRdata,

    input  logic                      fetchEn,
    input  logic [`FETCH_ADDR_W-1:0]  fetchAddr,
    output logic [2*`IRAM_W-1:0]      fetchData,
    output logic                      fetchBusy,

    output logic                      extEn,
    output logic                      extOen,
    output logic [`MEM_DATA_W-1:0]    extBusOut,
    input  logic [`MEM_DATA_W-1:0]    extBusIn
);

    RamReq                     mcReq;
    MemTarget                  mcTarget;
    logic [`MEM_DATA_W-1:0]    mcRdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RAM port wiring
    logic                      dramNce;
    logic                      dramNwe;
    logic [`DRAM_ADDR_W-1:0]   dramAddr;
    logic [`MEM_DATA_W-1:0]    dramData;
    logic [3:0]                dramWm;
    logic [`MEM_DATA_W-1:0]    dramRdata;
    logic                      dramNce1;
    logic [`DRAM_ADDR_W-1:0]   dramAddr1;
    logic [`MEM_DATA_W-1:0]    dramRdata1;

    logic                      iramNce;
    logic                      iramNwe;
    logic [`IRAM_ADDR_W-1:0]   iramAddr;
    logic [`IRAM_W-1:0]        iramData;
    logic [`IRAM_W/8-1:0]      iramWm;
    logic [`IRAM_W-1:0]        iramRdata;
    logic                      iramNce1;
    logic [`IRAM_ADDR_W-1:0]   iramAddr1;
    logic [`IRAM_W-1:0]        iramRdata1;

    memController i_memController (
        .SPI_clk   (SPI_clk),
        .arstN     (arstN),
        .cmd       (cmd),
        .cmdValid  (cmdValid),
        .cmdReady  (cmdReady),
        .stat      (stat),
        .mcReq     (mcReq),
        .mcTarget  (mcTarget),
        .mcRdata   (mcRdata),
        .extEn     (extEn),
        .extOen    (extOen),
        .extBusOut (extBusOut),
        .extBusIn  (extBusIn)
    );

    ramArbiter i_ramArbiter (
        .SPI_clk    (SPI_clk),
        .mcReq      (mcReq),
        .mcTarget   (mcTarget),
        .mcRdata    (mcRdata),
        .dataWr     (dataWr),
        .dataRe     (dataRe),
        .dataRaddr  (dataRaddr),
        .dataRdata  (dataRdata),
        .dataWbusy  (dataWbusy),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .fetchData  (fetchData),
        .fetchBusy  (fetchBusy),
        .dramNce    (dramNce),
        .dramNwe    (dramNwe),
        .dramAddr   (dramAddr),
        .dramData   (dramData),
        .dramWm     (dramWm),
        .dramRdata  (dramRdata),
        .dramNce1   (dramNce1),
        .dramAddr1  (dramAddr1),
        .dramRdata1 (dramRdata1),
        .iramNce    (iramNce),
        .iramNwe    (iramNwe),
        .iramAddr   (iramAddr),
        .iramData   (iramData),
        .iramWm     (iramWm),
        .iramRdata  (iramRdata),
        .iramNce1   (iramNce1),
        .iramAddr1  (iramAddr1),
        .iramRdata1 (iramRdata1)
    );

    dualPortRam #(
        .WIDTH (`MEM_DATA_W),
        .DEPTH (`DRAM_DEPTH)
    ) dataRam (
        .SPI_clk (SPI_clk),
        .nce     (dramNce),
        .nwe     (dramNwe),
        .addr    (dramAddr),
        .data    (dramData),
        .wm      (dramWm),
        .rdata   (dramRdata),
        .nce1    (dramNce1),
        .addr1   (dramAddr1),
        .rdata1  (dramRdata1)
    );

    dualPortRam #(
        .WIDTH (`IRAM_W),
        .DEPTH (`IRAM_DEPTH)
    ) instrRam (
        .SPI_clk (SPI_clk),
        .nce     (iramNce),
        .nwe     (iramNwe),
        .addr    (iramAddr),
        .data    (iramData),
        .wm      (iramWm),
        .rdata   (iramRdata),
        .nce1    (iramNce1),
        .addr1   (iramAddr1),
        .rdata1  (iramRdata1)
    );

endmodule

//--- sim/extMemModel.sv
`timescale 1ns/10ps
`include "memSys_consts.svh"

module extMemModel (
    input  logic                    SPI_clk,
    input  logic                    arstN,

    input  logic                    extEn,
    input  logic                    extOen,
    input  logic [`MEM_DATA_W-1:0]  extBusOut,
    output logic [`MEM_DATA_W-1:0]  extBusIn,

    output logic                    wrSeen,     // One pulse per stored word
    output logic [`EXT_ADDR_W-1:0]  wrAddr,
    output logic [`MEM_DATA_W-1:0]  wrData
);

    logic [`MEM_DATA_W-1:0] mem [logic [`EXT_ADDR_W-1:0]];
    logic                   active;
    logic                   wrBurst;
    logic [`EXT_ADDR_W-1:0] base;
    int unsigned            cnt;        // Bus cycle index within the burst

    // Untouched words read as the fill pattern
    function automatic logic [`MEM_DATA_W-1:0] wordAt(logic [`EXT_ADDR_W-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {~a[15:0], a[15:0]};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus slave
    always @(posedge SPI_clk or negedge arstN) begin
        if (!arstN) begin
            active   <= 1'b0;
            wrBurst  <= 1'b0;
            base     <= '0;
            cnt      <= 0;
            extBusIn <= '0;
            wrSeen   <= 1'b0;
            wrAddr   <= '0;
            wrData   <= '0;
        end else begin
            wrSeen   <= 1'b0;
            extBusIn <= '0;
            if (!extEn) begin
                active <= 1'b0;
            end else if (!active) begin
                active  <= 1'b1;                        // Command word
                wrBurst <= extBusOut[31];
                base    <= extBusOut[`EXT_ADDR_W-1:0];
                cnt     <= 1;
            end else begin
                cnt <= cnt + 1;
                if (wrBurst && extOen) begin
                    mem[base + `EXT_ADDR_W'(cnt - 1)] = extBusOut;
                    wrSeen <= 1'b1;
                    wrAddr <= base + `EXT_ADDR_W'(cnt - 1);
                    wrData <= extBusOut;
                end
                if (!wrBurst && (cnt + 1 >= `EXT_RD_LAT)) begin
                    extBusIn <= wordAt(base + `EXT_ADDR_W'(cnt + 1 - `EXT_RD_LAT));
                end
            end
        end
    end

endmodule

//--- sim/memSys_tb.sv
`timescale 1ns/10ps
`include "memSys_consts.svh"

module memSys_tb
    import memSysPkg::*;
();

    localparam int CLK_HALF   = 10;
    localparam int NUM_BURSTS = 7;

    logic                      SPI_clk;
    logic                      arstN;
    MemCmd                     cmd;
    logic                      cmdValid;
    logic                      cmdReady;
    MemStat                    stat;
    RamReq                     dataWr;
    logic                      dataWbusy;
    logic                      dataRe;
    logic [`DRAM_ADDR_W-1:0]   dataRaddr;
    logic [`MEM_DATA_W-1:0]    dataRdata;
    logic                      fetchEn;
    logic [`FETCH_ADDR_W-1:0]  fetchAddr;
    logic [2*`IRAM_W-1:0]      fetchData;
    logic                      fetchBusy;
    logic                      extEn;
    logic                      extOen;
    logic [`MEM_DATA_W-1:0]    extBusOut;
    logic [`MEM_DATA_W-1:0]    extBusIn;
    logic                      wrSeen;
    logic [`EXT_ADDR_W-1:0]    wrAddr;
    logic [`MEM_DATA_W-1:0]    wrData;

    logic [31:0]               lfsr = 32'he4a4;
    int                        errCnt = 0;
    int                        chkCnt = 0;
    int                        acceptCnt = 0;
    int                        doneCnt = 0;
    int                        budget = 0;          // Watchdog limit in cycles
    logic [`EXT_ADDR_W-1:0]    storeAddrQ [$];
    logic [`MEM_DATA_W-1:0]    storeDataQ [$];

    initial SPI_clk = 1'b0;
    always #CLK_HALF SPI_clk = ~SPI_clk;

    memSys i_memSys (
        .SPI_clk   (SPI_clk),
        .arstN     (arstN),
        .cmd       (cmd),
        .cmdValid  (cmdValid),
        .cmdReady  (cmdReady),
        .stat      (stat),
        .dataWr    (dataWr),
        .dataWbusy (dataWbusy),
        .dataRe    (dataRe),
        .dataRaddr (dataRaddr),
        .dataRdata (dataRdata),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchData (fetchData),
        .fetchBusy (fetchBusy),
        .extEn     (extEn),
        .extOen    (extOen),
        .extBusOut (extBusOut),
        .extBusIn  (extBusIn)
    );

    extMemModel extMem (
        .SPI_clk   (SPI_clk),
        .arstN     (arstN),
        .extEn     (extEn),
        .extOen    (extOen),
        .extBusOut (extBusOut),
        .extBusIn  (extBusIn),
        .wrSeen    (wrSeen),
        .wrAddr    (wrAddr),
        .wrData    (wrData)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Monitors and protocol assertions
    always @(posedge SPI_clk) begin
        if (arstN) begin
            if (cmdValid && cmdReady) begin
                acceptCnt++;
            end
            if (stat.done) begin
                doneCnt++;
            end
            if (wrSeen) begin
                storeAddrQ.push_back(wrAddr);
                storeDataQ.push_back(wrData);
            end
        end
    end

    aDoneOnce: assert property (@(posedge SPI_clk) disable iff (!arstN)
        stat.done |=> !stat.done)
        else begin
            errCnt++;
            $display("The done pulse lasted longer than one cycle");
        end

    aBusyNotReady: assert property (@(posedge SPI_clk) disable iff (!arstN)
        stat.busy |-> !cmdReady)
        else begin
            errCnt++;
            $display("cmdReady was high while the controller was busy");
        end

    initial begin
        wait (budget != 0);
        repeat (budget) @(posedge SPI_clk);
        $display("Timeout after %0d cycles, a transfer never finished", budget);
        $display("TESTS FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] pattern(logic [`EXT_ADDR_W-1:0] a);
        return {~a[15:0], a[15:0]};
    endfunction

    task automatic expectEq(string name, logic [127:0] got, logic [127:0] exp);
        chkCnt++;
        assert (got === exp) else begin
            errCnt++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic expectTrue(logic cond, string failText);
        chkCnt++;
        assert (cond) else begin
            errCnt++;
            $display("%s", failText);
        end
    endtask

    task automatic setCmd(MemOp op, MemTarget tgt, logic [9:0] sAddr,
                          logic [29:0] eAddr, int len);
        cmd.op       = op;
        cmd.target   = tgt;
        cmd.sramAddr = sAddr;
        cmd.extAddr  = eAddr;
        cmd.len      = 8'(len);
        cmdValid     = 1'b1;
    endtask

    task automatic sendCmd(MemOp op, MemTarget tgt, logic [9:0] sAddr,
                           logic [29:0] eAddr, int len);
        @(negedge SPI_clk);
        setCmd(op, tgt, sAddr, eAddr, len);
        while (!cmdReady) @(negedge SPI_clk);
        @(negedge SPI_clk);
        cmdValid = 1'b0;
    endtask

    task automatic waitDone();
        while (!stat.done) @(negedge SPI_clk);
    endtask

    task automatic runCmd(MemOp op, MemTarget tgt, logic [9:0] sAddr,
                          logic [29:0] eAddr, int len);
        sendCmd(op, tgt, sAddr, eAddr, len);
        waitDone();
    endtask

    task automatic writeWord(logic [9:0] addr, logic [31:0] data, logic [3:0] mask,
                             output logic sawBusy);
        @(negedge SPI_clk);
        dataWr.ce   = 1'b1;
        dataWr.we   = 1'b1;
        dataWr.wm   = mask;
        dataWr.addr = addr;
        dataWr.data = data;
        sawBusy     = dataWbusy;
        while (dataWbusy) @(negedge SPI_clk);       // Held until the port frees up
        @(negedge SPI_clk);
        dataWr = '0;
    endtask

    task automatic readWord(logic [9:0] addr, output logic [31:0] data);
        @(negedge SPI_clk);
        dataRe    = 1'b1;
        dataRaddr = addr;
        @(negedge SPI_clk);
        dataRe = 1'b0;
        data   = dataRdata;
    endtask

    task automatic fetchLine(logic [7:0] line, output logic [127:0] data);
        @(negedge SPI_clk);
        fetchEn   = 1'b1;
        fetchAddr = line;
        @(negedge SPI_clk);
        fetchEn = 1'b0;
        data    = fetchData;
    endtask

    task automatic checkLoad(logic [9:0] sAddr, logic [29:0] eAddr, int len);
        logic [31:0] got;
        for (int i = 0; i < len; i++) begin
            readWord(sAddr + 10'(i), got);
            expectEq($sformatf("dataRdata[%0h]", sAddr + 10'(i)), got,
                     pattern(eAddr + 30'(i)));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    initial begin
        int           len2;
        int           len3;
        int           len5;
        int           len6a;
        int           len6b;
        int           doneBase;
        logic [9:0]   sAddr;
        logic [9:0]   offs;
        logic [29:0]  eAddr;
        logic [29:0]  eAddr2;
        logic [3:0]   mask;
        logic [31:0]  wData;
        logic [31:0]  got;
        logic [31:0]  exp;
        logic [127:0] line;
        logic [127:0] lineExp;
        logic         sawBusy;
        logic         sawDone;
        logic [31:0]  srcData [16];

        arstN     = 1'b0;
        cmd       = '0;
        cmdValid  = 1'b0;
        dataWr    = '0;
        dataRe    = 1'b0;
        dataRaddr = '0;
        fetchEn   = 1'b0;
        fetchAddr = '0;

        len2   = 1 + int'(randBits(5));
        len3   = 4 + int'(randBits(4));              // Long enough to overlap a write
        len5   = 1 + int'(randBits(4));
        len6a  = 1 + int'(randBits(3));
        len6b  = 1 + int'(randBits(3));
        budget = 8 * (len2 + len3 + 8 + 2 * len5 + len6a + len6b) + 40 * NUM_BURSTS;

        repeat (2) @(negedge SPI_clk);
        arstN = 1'b1;

        // 1. Reset values
        @(negedge SPI_clk);
        expectEq("cmdReady", cmdReady, 1);
        expectEq("stat.busy", stat.busy, 0);
        expectEq("stat.done", stat.done, 0);
        expectEq("extEn", extEn, 0);
        expectEq("extOen", extOen, 0);
        expectEq("dataWbusy", dataWbusy, 0);
        expectEq("fetchBusy", fetchBusy, 0);

        // 2. Data RAM load
        sAddr = 10'(randBits(10));
        eAddr = 30'(randBits(30));
        runCmd(MOP_LOAD, TGT_DATA, sAddr, eAddr, len2);
        checkLoad(sAddr, eAddr, len2);

        // 3. Masked processor write held off by a load into the same region
        sAddr = 10'(randBits(10));
        eAddr = 30'(randBits(30));
        offs  = 10'(randBits(2));
        mask  = (4'(randBits(4)) | 4'b0001) & 4'b1011;
        wData = randBits(32);
        sendCmd(MOP_LOAD, TGT_DATA, sAddr, eAddr, len3);
        while (!extEn) @(negedge SPI_clk);
        writeWord(sAddr + offs, wData, mask, sawBusy);
        expectTrue(sawBusy, "dataWbusy stayed low during a data RAM load");
        expectTrue(!stat.busy, "Controller still busy after the held write completed");
        exp = pattern(eAddr + 30'(offs));
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                exp[b*8 +: 8] = wData[b*8 +: 8];
            end
        end
        readWord(sAddr + offs, got);
        expectEq($sformatf("dataRdata[%0h]", sAddr + offs), got, exp);

        // 4. Instruction RAM load, two fetch lines
        sAddr = {7'(randBits(7)), 3'b000};
        eAddr = 30'(randBits(30));
        sendCmd(MOP_LOAD, TGT_INSTR, sAddr, eAddr, 8);
        while (!extEn) @(negedge SPI_clk);
        expectEq("fetchBusy", fetchBusy, 1);
        waitDone();
        for (int l = 0; l < 2; l++) begin
            for (int k = 0; k < 4; k++) begin
                lineExp[k*32 +: 32] = pattern(eAddr + 30'(4 * l + k));
            end
            fetchLine(8'(sAddr >> 2) + 8'(l), line);
            expectEq($sformatf("fetchData[%0h]", 8'(sAddr >> 2) + 8'(l)), line, lineExp);
        end

        // 5. Store to external memory, then load it back elsewhere
        sAddr = 10'(randBits(10));
        eAddr = 30'(randBits(30));
        for (int i = 0; i < len5; i++) begin
            srcData[i] = randBits(32);
            writeWord(sAddr + 10'(i), srcData[i], 4'hf, sawBusy);
        end
        storeAddrQ.delete();
        storeDataQ.delete();
        runCmd(MOP_STORE, TGT_DATA, sAddr, eAddr, len5);
        @(negedge SPI_clk);                          // Last stored word reaches the queues
        expectEq("stored word count", storeAddrQ.size(), len5);
        for (int i = 0; i < len5 && i < storeAddrQ.size(); i++) begin
            expectEq("wrAddr", storeAddrQ[i], eAddr + 30'(i));
            expectEq("wrData", storeDataQ[i], srcData[i]);
        end
        runCmd(MOP_LOAD, TGT_DATA, sAddr + 10'd512, eAddr, len5);
        for (int i = 0; i < len5; i++) begin
            readWord(sAddr + 10'd512 + 10'(i), got);
            expectEq($sformatf("dataRdata[%0h]", sAddr + 10'd512 + 10'(i)), got, srcData[i]);
        end

        // 6. Second command waits for the first
        sAddr    = 10'(randBits(10));
        eAddr    = 30'(randBits(30));
        eAddr2   = 30'(randBits(30));
        doneBase = doneCnt;
        sendCmd(MOP_LOAD, TGT_DATA, sAddr, eAddr, len6a);
        expectEq("stat.busy", stat.busy, 1);
        setCmd(MOP_LOAD, TGT_DATA, sAddr + 10'd256, eAddr2, len6b);
        expectEq("cmdReady", cmdReady, 0);
        sawDone = 1'b0;
        while (!cmdReady) begin
            @(negedge SPI_clk);
            if (stat.done) begin
                sawDone = 1'b1;
            end
        end
        @(negedge SPI_clk);
        cmdValid = 1'b0;
        expectTrue(sawDone, "Second command was accepted before the first one finished");
        waitDone();
        checkLoad(sAddr, eAddr, len6a);
        checkLoad(sAddr + 10'd256, eAddr2, len6b);
        expectEq("done pulses", doneCnt - doneBase, 2);

        expectEq("done pulses vs commands", doneCnt, acceptCnt);
        $display("Checks: %0d, errors: %0d", chkCnt, errCnt);
        if (errCnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/memSysPkg.sv
rtl/dualPortRam.sv
rtl/extBusMaster.sv
rtl/memController.sv
rtl/ramArbiter.sv
rtl/memSys.sv
sim/extMemModel.sv
sim/memSys_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = memSys_tb
FILELIST  = project.f
OBJDIR    = obj_dir

BIN     = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) rtl/memSys_consts.svh

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)
